// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input wire logic clk,
	input wire logic rst,
	input wire cpu_isa_pkg::opcode_t opcode, // Byte on the data bus
	input wire logic branch_valid,
	output logic instruction_load,
	output logic increment_pc,
	output logic dirl_load,
	output logic dirh_load,
	output logic a_load,
	output logic branch_load,
	output logic jmp_load,
	output logic jsr_load,
	output cu_ctrl_pkg::sp_op_e sp_op,
	output logic read_write,
	output cu_ctrl_pkg::wr_sel_e write_select,
	output cu_ctrl_pkg::addr_sel_e address_select,
	output cpu_isa_pkg::alu_sel_e alu_select,
	output cpu_isa_pkg::alu_op_e alu_opcode
);

	cpu_isa_pkg::opcode_t opcode_reg;
	cu_ctrl_pkg::cu_state_e state;

	decode_if dec_bus ();

	state_sequencer i_state_sequencer (
		.clk          (clk),
		.rst          (rst),
		.opcode       (opcode),
		.branch_valid (branch_valid),
		.dec          (dec_bus.sequencer),
		.opcode_reg   (opcode_reg),
		.state        (state)
	);

	instruction_decoder i_instruction_decoder (
		.opcode_reg (opcode_reg),
		.dec        (dec_bus.decoder)
	);

	micro_op_decoder i_micro_op_decoder (
		.state            (state),
		.dec              (dec_bus.micro_op),
		.instruction_load (instruction_load),
		.increment_pc     (increment_pc),
		.dirl_load        (dirl_load),
		.dirh_load        (dirh_load),
		.a_load           (a_load),
		.branch_load      (branch_load),
		.jmp_load         (jmp_load),
		.jsr_load         (jsr_load),
		.sp_op            (sp_op),
		.read_write       (read_write),
		.write_select     (write_select),
		.address_select   (address_select),
		.alu_select       (alu_select),
		.alu_opcode       (alu_opcode)
	);

endmodule

`default_nettype wire

// ==== rtl/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

	typedef logic [7:0] opcode_t;

	// ALU operation codes as the datapath expects them
	typedef enum logic [5:0] {
		ADR0 = 6'd0,  // Address low byte
		ADR1 = 6'd1,  // Address high byte
		ADC  = 6'd2,
		AND  = 6'd3,
		ASL  = 6'd4,
		BCC  = 6'd6,
		BNE  = 6'd7,
		BVC  = 6'd12,
		BPL  = 6'd13,
		BCS  = 6'd14,
		BEQ  = 6'd15,
		BVS  = 6'd20,
		BMI  = 6'd21,
		BRA  = 6'd22,
		CMP  = 6'd27,
		DEC  = 6'd28,
		EOR  = 6'd29,
		INC  = 6'd30,
		LD   = 6'd31, // Pass memory operand
		PASS = 6'd32, // Pass selected register
		LSR  = 6'd33,
		ORA  = 6'd34,
		ROL  = 6'd43,
		ROR  = 6'd44,
		SBC  = 6'd45
	} alu_op_e;

	// ALU operand source
	typedef enum logic [2:0] {
		A = 3'b000,
		F = 3'b001, // Flags
		M = 3'b010, // Memory
		Z = 3'b110  // Zero page base
	} alu_sel_e;

	// Opcode fields, group in bits 1..0 and mode in bits 4..2
	localparam logic [1:0] GROUP_ACC = 2'b01;
	localparam logic [1:0] GROUP_RMW = 2'b10;
	localparam logic [2:0] MODE_IMM = 3'b010;
	localparam logic [2:0] MODE_ZP = 3'b001;
	localparam logic [2:0] MODE_ABS = 3'b011;

	localparam opcode_t OP_PHA = 8'h48;
	localparam opcode_t OP_PLA = 8'h68;
	localparam opcode_t OP_JMP = 8'h4C;
	localparam opcode_t OP_JSR = 8'h20;
	localparam opcode_t OP_BRA = 8'h80;
	localparam opcode_t OP_STA_IMM = 8'h89;

	// Shift or step on memory; aaa values 4 and 5 are STX and LDX
	function automatic logic rmw_valid(input opcode_t op);
		return (op[1:0] == GROUP_RMW) && (op[7:6] != 2'b10) &&
			((op[4:2] == MODE_ZP) || (op[4:2] == MODE_ABS));
	endfunction

	function automatic logic is_branch(input opcode_t op);
		return ((op[3:0] == 4'h0) && op[4]) || (op == OP_BRA);
	endfunction

endpackage

`default_nettype wire

// ==== rtl/cu_ctrl_pkg.sv ====
`default_nettype none

package cu_ctrl_pkg;

	typedef enum logic [4:0] {
		FETCH,
		IM0,
		ZP0,
		ZP1,
		ZP_STORE,
		ZP_WRITE,
		ABS0,
		ABS1,
		ABS2,
		ABS_STORE,
		ABS_WRITE,
		ABS_JMP,
		JSR0,
		JSR1,
		JSR2,
		BRANCH_CHECK,
		BRANCH_GO,
		PUSH,
		PULL
	} cu_state_e;

	// Address mux of the datapath
	typedef enum logic [3:0] {
		PC    = 4'b0000,
		ZERO  = 4'b0001,
		ABS   = 4'b0010,
		STACK = 4'b0111
	} addr_sel_e;

	// Write data mux
	typedef enum logic [2:0] {
		ALU    = 3'b000,
		RESULT = 3'b001,
		PCL    = 3'b010,
		PCH    = 3'b011
	} wr_sel_e;

	typedef enum logic [1:0] {
		HOLD = 2'b00,
		INC  = 2'b01,
		DEC  = 2'b10
	} sp_op_e;

	localparam logic RW_READ = 1'b0;
	localparam logic RW_WRITE = 1'b1;

endpackage

`default_nettype wire

// ==== rtl/decode_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

	logic is_store;
	logic is_rmw;
	logic is_jmp;
	logic is_jsr;
	logic loads_a;                     // Execute phase writes A
	cpu_isa_pkg::alu_op_e alu_op;      // Execute phase operation
	cpu_isa_pkg::alu_sel_e alu_sel_ex; // Execute phase operand

	modport decoder (
		output is_store, is_rmw, is_jmp, is_jsr, loads_a, alu_op, alu_sel_ex
	);
	modport sequencer (input is_store, is_rmw, is_jmp, is_jsr);
	modport micro_op (input loads_a, alu_op, alu_sel_ex);

endinterface

`default_nettype wire

// ==== rtl/instruction_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder (
	input wire cpu_isa_pkg::opcode_t opcode_reg,
	decode_if.decoder dec
);

	logic [2:0] aaa;
	logic acc_op;
	cpu_isa_pkg::alu_op_e branch_test;

	assign aaa = opcode_reg[7:5];
	assign acc_op = (opcode_reg[1:0] == cpu_isa_pkg::GROUP_ACC);

	assign dec.is_store = acc_op && (aaa == 3'd4); // STA
	assign dec.is_rmw = cpu_isa_pkg::rmw_valid(opcode_reg);
	assign dec.is_jmp = (opcode_reg == cpu_isa_pkg::OP_JMP);
	assign dec.is_jsr = (opcode_reg == cpu_isa_pkg::OP_JSR);

	// Everything in the group except STA and CMP lands in A
	assign dec.loads_a = (acc_op && (aaa != 3'd4) && (aaa != 3'd6)) ||
		(opcode_reg == cpu_isa_pkg::OP_PLA);

	// Flag tested by a conditional branch, bit 5 picks the set polarity
	always_comb begin
		case ({opcode_reg[5], opcode_reg[7:6]})
			3'b000: branch_test = cpu_isa_pkg::BPL;
			3'b001: branch_test = cpu_isa_pkg::BVC;
			3'b010: branch_test = cpu_isa_pkg::BCC;
			3'b011: branch_test = cpu_isa_pkg::BNE;
			3'b100: branch_test = cpu_isa_pkg::BMI;
			3'b101: branch_test = cpu_isa_pkg::BVS;
			3'b110: branch_test = cpu_isa_pkg::BCS;
			default: branch_test = cpu_isa_pkg::BEQ;
		endcase
	end

	always_comb begin
		dec.alu_op = cpu_isa_pkg::PASS;
		dec.alu_sel_ex = cpu_isa_pkg::M;
		if (opcode_reg == cpu_isa_pkg::OP_BRA) begin
			dec.alu_op = cpu_isa_pkg::BRA;
			dec.alu_sel_ex = cpu_isa_pkg::F;
		end else if (cpu_isa_pkg::is_branch(opcode_reg)) begin
			dec.alu_op = branch_test;
			dec.alu_sel_ex = cpu_isa_pkg::F;
		end else if (opcode_reg == cpu_isa_pkg::OP_PLA) begin
			dec.alu_op = cpu_isa_pkg::LD;
		end else if (opcode_reg == cpu_isa_pkg::OP_PHA) begin
			dec.alu_sel_ex = cpu_isa_pkg::A; // Push A through the ALU
		end else if (acc_op) begin
			dec.alu_sel_ex = cpu_isa_pkg::A;
			case (aaa)
				3'd0: dec.alu_op = cpu_isa_pkg::ORA;
				3'd1: dec.alu_op = cpu_isa_pkg::AND;
				3'd2: dec.alu_op = cpu_isa_pkg::EOR;
				3'd3: dec.alu_op = cpu_isa_pkg::ADC;
				3'd4: dec.alu_op = cpu_isa_pkg::PASS; // STA
				3'd5: dec.alu_op = cpu_isa_pkg::LD;
				3'd6: dec.alu_op = cpu_isa_pkg::CMP;
				default: dec.alu_op = cpu_isa_pkg::SBC;
			endcase
		end else if (dec.is_rmw) begin
			case (aaa)
				3'd0: dec.alu_op = cpu_isa_pkg::ASL;
				3'd1: dec.alu_op = cpu_isa_pkg::ROL;
				3'd2: dec.alu_op = cpu_isa_pkg::LSR;
				3'd3: dec.alu_op = cpu_isa_pkg::ROR;
				3'd6: dec.alu_op = cpu_isa_pkg::DEC;
				default: dec.alu_op = cpu_isa_pkg::INC;
			endcase
		end
	end

	// The sequencer branches on these, two at once would be ambiguous
	always_comb begin
		assert #0 ($onehot0({dec.is_store, dec.is_rmw, dec.is_jmp, dec.is_jsr}))
			else $error("decode flags overlap for opcode %02h", opcode_reg);
	end

endmodule

`default_nettype wire

// ==== rtl/micro_op_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module micro_op_decoder (
	input wire cu_ctrl_pkg::cu_state_e state,
	decode_if.micro_op dec,
	output logic instruction_load,
	output logic increment_pc,
	output logic dirl_load,
	output logic dirh_load,
	output logic a_load,
	output logic branch_load,
	output logic jmp_load,
	output logic jsr_load,
	output cu_ctrl_pkg::sp_op_e sp_op,
	output logic read_write,
	output cu_ctrl_pkg::wr_sel_e write_select,
	output cu_ctrl_pkg::addr_sel_e address_select,
	output cpu_isa_pkg::alu_sel_e alu_select,
	output cpu_isa_pkg::alu_op_e alu_opcode
);

	assign instruction_load = (state == cu_ctrl_pkg::FETCH);
	assign dirl_load = (state == cu_ctrl_pkg::ZP0) || (state == cu_ctrl_pkg::ABS0);
	assign dirh_load = (state == cu_ctrl_pkg::ABS1);
	assign jmp_load = (state == cu_ctrl_pkg::ABS_JMP);
	assign jsr_load = (state == cu_ctrl_pkg::JSR2);
	assign branch_load = (state == cu_ctrl_pkg::BRANCH_GO);

	// Every cycle that consumes an opcode or operand byte
	assign increment_pc = state inside {cu_ctrl_pkg::FETCH, cu_ctrl_pkg::IM0,
		cu_ctrl_pkg::ZP0, cu_ctrl_pkg::ABS0, cu_ctrl_pkg::ABS1, cu_ctrl_pkg::BRANCH_CHECK};

	assign a_load = dec.loads_a && (state inside {cu_ctrl_pkg::IM0, cu_ctrl_pkg::ZP1,
		cu_ctrl_pkg::ABS2, cu_ctrl_pkg::PULL});

	always_comb begin
		case (state)
			cu_ctrl_pkg::PUSH,
			cu_ctrl_pkg::JSR0,
			cu_ctrl_pkg::JSR1: sp_op = cu_ctrl_pkg::DEC;
			cu_ctrl_pkg::PULL: sp_op = cu_ctrl_pkg::INC;
			default: sp_op = cu_ctrl_pkg::HOLD;
		endcase
	end

	assign read_write = (state inside {cu_ctrl_pkg::ZP_STORE, cu_ctrl_pkg::ZP_WRITE,
		cu_ctrl_pkg::ABS_STORE, cu_ctrl_pkg::ABS_WRITE, cu_ctrl_pkg::PUSH,
		cu_ctrl_pkg::JSR0, cu_ctrl_pkg::JSR1}) ? cu_ctrl_pkg::RW_WRITE : cu_ctrl_pkg::RW_READ;

	always_comb begin
		case (state)
			cu_ctrl_pkg::ZP_WRITE,
			cu_ctrl_pkg::ABS_WRITE: write_select = cu_ctrl_pkg::RESULT;
			cu_ctrl_pkg::JSR0: write_select = cu_ctrl_pkg::PCH; // High byte pushed first
			cu_ctrl_pkg::JSR1: write_select = cu_ctrl_pkg::PCL;
			default: write_select = cu_ctrl_pkg::ALU;
		endcase
	end

	always_comb begin
		case (state)
			cu_ctrl_pkg::ZP1,
			cu_ctrl_pkg::ZP_STORE,
			cu_ctrl_pkg::ZP_WRITE: address_select = cu_ctrl_pkg::ZERO;
			cu_ctrl_pkg::ABS2,
			cu_ctrl_pkg::ABS_STORE,
			cu_ctrl_pkg::ABS_WRITE: address_select = cu_ctrl_pkg::ABS;
			cu_ctrl_pkg::PUSH,
			cu_ctrl_pkg::PULL,
			cu_ctrl_pkg::JSR0,
			cu_ctrl_pkg::JSR1: address_select = cu_ctrl_pkg::STACK;
			default: address_select = cu_ctrl_pkg::PC;
		endcase
	end

	always_comb begin
		case (state)
			cu_ctrl_pkg::ZP0,
			cu_ctrl_pkg::ABS0: alu_select = cpu_isa_pkg::Z; // Address phase
			cu_ctrl_pkg::IM0,
			cu_ctrl_pkg::ZP1,
			cu_ctrl_pkg::ABS2,
			cu_ctrl_pkg::ZP_STORE,
			cu_ctrl_pkg::ABS_STORE,
			cu_ctrl_pkg::PUSH,
			cu_ctrl_pkg::BRANCH_CHECK: alu_select = dec.alu_sel_ex;
			default: alu_select = cpu_isa_pkg::M;
		endcase
	end

	always_comb begin
		case (state)
			cu_ctrl_pkg::ZP0,
			cu_ctrl_pkg::ABS0: alu_opcode = cpu_isa_pkg::ADR0;
			cu_ctrl_pkg::ABS1: alu_opcode = cpu_isa_pkg::ADR1;
			cu_ctrl_pkg::IM0,
			cu_ctrl_pkg::ZP1,
			cu_ctrl_pkg::ABS2,
			cu_ctrl_pkg::BRANCH_CHECK: alu_opcode = dec.alu_op;
			default: alu_opcode = cpu_isa_pkg::PASS;
		endcase
	end

	// Writing through the program counter would overwrite code
	always_comb begin
		assert #0 (!((read_write == cu_ctrl_pkg::RW_WRITE) &&
			(address_select == cu_ctrl_pkg::PC)))
			else $error("write cycle on PC address in state %s", state.name());
	end

endmodule

`default_nettype wire

// ==== rtl/state_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module state_sequencer (
	input wire logic clk,
	input wire logic rst,
	input wire cpu_isa_pkg::opcode_t opcode,
	input wire logic branch_valid,
	decode_if.sequencer dec,
	output cpu_isa_pkg::opcode_t opcode_reg,
	output cu_ctrl_pkg::cu_state_e state
);

	logic [2:0] mode;
	logic acc_op;
	logic rmw_op;
	cu_ctrl_pkg::cu_state_e dispatch_state;
	cu_ctrl_pkg::cu_state_e next_state;

	assign mode = opcode[4:2];
	assign acc_op = (opcode[1:0] == cpu_isa_pkg::GROUP_ACC);
	assign rmw_op = cpu_isa_pkg::rmw_valid(opcode);

	// First state of the opcode on the data bus
	always_comb begin
		if (acc_op && (mode == cpu_isa_pkg::MODE_IMM) && (opcode != cpu_isa_pkg::OP_STA_IMM))
			dispatch_state = cu_ctrl_pkg::IM0;
		else if ((acc_op || rmw_op) && (mode == cpu_isa_pkg::MODE_ZP))
			dispatch_state = cu_ctrl_pkg::ZP0;
		else if (((acc_op || rmw_op) && (mode == cpu_isa_pkg::MODE_ABS)) ||
				(opcode == cpu_isa_pkg::OP_JMP) || (opcode == cpu_isa_pkg::OP_JSR))
			dispatch_state = cu_ctrl_pkg::ABS0;
		else if (cpu_isa_pkg::is_branch(opcode))
			dispatch_state = cu_ctrl_pkg::BRANCH_CHECK;
		else if (opcode == cpu_isa_pkg::OP_PHA)
			dispatch_state = cu_ctrl_pkg::PUSH;
		else if (opcode == cpu_isa_pkg::OP_PLA)
			dispatch_state = cu_ctrl_pkg::PULL;
		else
			dispatch_state = cu_ctrl_pkg::FETCH; // Unsupported, one cycle no-op
	end

	always_comb begin
		case (state)
			cu_ctrl_pkg::FETCH: next_state = dispatch_state;
			cu_ctrl_pkg::ZP0:
				next_state = dec.is_store ? cu_ctrl_pkg::ZP_STORE : cu_ctrl_pkg::ZP1;
			cu_ctrl_pkg::ZP1:
				next_state = dec.is_rmw ? cu_ctrl_pkg::ZP_WRITE : cu_ctrl_pkg::FETCH;
			cu_ctrl_pkg::ABS0:
				next_state = dec.is_jmp ? cu_ctrl_pkg::ABS_JMP : cu_ctrl_pkg::ABS1;
			cu_ctrl_pkg::ABS1: begin
				if (dec.is_store)
					next_state = cu_ctrl_pkg::ABS_STORE;
				else if (dec.is_jsr)
					next_state = cu_ctrl_pkg::JSR0; // Push return address
				else
					next_state = cu_ctrl_pkg::ABS2;
			end
			cu_ctrl_pkg::ABS2:
				next_state = dec.is_rmw ? cu_ctrl_pkg::ABS_WRITE : cu_ctrl_pkg::FETCH;
			cu_ctrl_pkg::BRANCH_CHECK:
				next_state = branch_valid ? cu_ctrl_pkg::BRANCH_GO : cu_ctrl_pkg::FETCH;
			cu_ctrl_pkg::JSR0: next_state = cu_ctrl_pkg::JSR1;
			cu_ctrl_pkg::JSR1: next_state = cu_ctrl_pkg::JSR2;
			default: next_state = cu_ctrl_pkg::FETCH; // Terminal states
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= cu_ctrl_pkg::FETCH;
			opcode_reg <= '0;
		end else begin
			state <= next_state;
			if (state == cu_ctrl_pkg::FETCH)
				opcode_reg <= opcode; // Instruction register
		end
	end

	a_jsr_chain: assert property (@(posedge clk) disable iff (!rst)
		state == cu_ctrl_pkg::JSR0 |=> state == cu_ctrl_pkg::JSR1);

	a_branch_taken: assert property (@(posedge clk) disable iff (!rst)
		state == cu_ctrl_pkg::BRANCH_GO |->
			$past(state) == cu_ctrl_pkg::BRANCH_CHECK && $past(branch_valid));

endmodule

`default_nettype wire

// ==== verification/tb_control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_control_unit;

	localparam int NUM_INSTR = 400;
	localparam int CYCLE_LIMIT = NUM_INSTR * 6 + 50; // Longest instruction is JSR

	typedef enum {FETCH, IM0, ZP0, ZP1, ZP_STORE, ZP_WRITE, ABS0, ABS1, ABS2, ABS_STORE,
		ABS_WRITE, ABS_JMP, JSR0, JSR1, JSR2, BRANCH_CHECK, BRANCH_GO, PUSH, PULL} model_state_e;

	logic clk;
	logic rst;
	logic [7:0] opcode;
	logic branch_valid;
	logic instruction_load;
	logic increment_pc;
	logic dirl_load;
	logic dirh_load;
	logic a_load;
	logic branch_load;
	logic jmp_load;
	logic jsr_load;
	logic read_write;
	logic [1:0] sp_op;
	logic [2:0] write_select;
	logic [3:0] address_select;
	logic [2:0] alu_select;
	logic [5:0] alu_opcode;

	model_state_e m_state;  // Reference state
	logic [7:0] m_op;       // Reference instruction register
	logic [7:0] supported[$];
	logic started;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int instr_done = 0;
	int len_count = 0;
	int exp_len = 0;
	int test_errors;

	control_unit i_control_unit (
		.clk              (clk),
		.rst              (rst),
		.opcode           (opcode),
		.branch_valid     (branch_valid),
		.instruction_load (instruction_load),
		.increment_pc     (increment_pc),
		.dirl_load        (dirl_load),
		.dirh_load        (dirh_load),
		.a_load           (a_load),
		.branch_load      (branch_load),
		.jmp_load         (jmp_load),
		.jsr_load         (jsr_load),
		.sp_op            (sp_op),
		.read_write       (read_write),
		.write_select     (write_select),
		.address_select   (address_select),
		.alu_select       (alu_select),
		.alu_opcode       (alu_opcode)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic acc_group(input logic [7:0] op);
		return op[1:0] == 2'b01;
	endfunction

	function automatic logic store_op(input logic [7:0] op);
		return acc_group(op) && (op[7:5] == 3'd4); // STA
	endfunction

	function automatic logic rmw_op(input logic [7:0] op);
		return (op[1:0] == 2'b10) && (op[7:5] != 3'd4) && (op[7:5] != 3'd5) &&
			((op[4:2] == 3'b001) || (op[4:2] == 3'b011));
	endfunction

	function automatic logic branch_op(input logic [7:0] op);
		return ((op[3:0] == 4'h0) && op[4]) || (op == 8'h80);
	endfunction

	function automatic logic loads_acc(input logic [7:0] op);
		return (acc_group(op) && (op[7:5] != 3'd4) && (op[7:5] != 3'd6)) || (op == 8'h68);
	endfunction

	function automatic model_state_e first_state(input logic [7:0] op);
		if (acc_group(op) && (op[4:2] == 3'b010) && (op != 8'h89))
			return IM0;
		if ((acc_group(op) || rmw_op(op)) && (op[4:2] == 3'b001))
			return ZP0;
		if (((acc_group(op) || rmw_op(op)) && (op[4:2] == 3'b011)) || (op == 8'h4C) ||
				(op == 8'h20))
			return ABS0;
		if (branch_op(op))
			return BRANCH_CHECK;
		if (op == 8'h48)
			return PUSH;
		if (op == 8'h68)
			return PULL;
		return FETCH;
	endfunction

	function automatic model_state_e advance(input model_state_e st, input logic [7:0] op,
			input logic bv);
		case (st)
			ZP0: return store_op(op) ? ZP_STORE : ZP1;
			ZP1: return rmw_op(op) ? ZP_WRITE : FETCH;
			ABS0: return (op == 8'h4C) ? ABS_JMP : ABS1;
			ABS1: return store_op(op) ? ABS_STORE : ((op == 8'h20) ? JSR0 : ABS2);
			ABS2: return rmw_op(op) ? ABS_WRITE : FETCH;
			BRANCH_CHECK: return bv ? BRANCH_GO : FETCH;
			JSR0: return JSR1;
			JSR1: return JSR2;
			default: return FETCH;
		endcase
	endfunction

	// Cycles per instruction before a taken branch adds one
	function automatic int cycles_for(input logic [7:0] op);
		case (first_state(op))
			IM0, BRANCH_CHECK, PUSH, PULL: return 2;
			ZP0: return rmw_op(op) ? 4 : 3;
			ABS0: begin
				if (op == 8'h4C)
					return 3;
				if (op == 8'h20)
					return 6;
				return rmw_op(op) ? 5 : 4;
			end
			default: return 1;
		endcase
	endfunction

	function automatic logic [5:0] exec_op(input logic [7:0] op);
		logic [5:0] acc_ops[8];
		logic [5:0] rmw_ops[8];
		logic [5:0] tests[8];
		acc_ops = '{cpu_isa_pkg::ORA, cpu_isa_pkg::AND, cpu_isa_pkg::EOR, cpu_isa_pkg::ADC,
			cpu_isa_pkg::PASS, cpu_isa_pkg::LD, cpu_isa_pkg::CMP, cpu_isa_pkg::SBC};
		rmw_ops = '{cpu_isa_pkg::ASL, cpu_isa_pkg::ROL, cpu_isa_pkg::LSR, cpu_isa_pkg::ROR,
			cpu_isa_pkg::PASS, cpu_isa_pkg::PASS, cpu_isa_pkg::DEC, cpu_isa_pkg::INC};
		tests = '{cpu_isa_pkg::BPL, cpu_isa_pkg::BVC, cpu_isa_pkg::BCC, cpu_isa_pkg::BNE,
			cpu_isa_pkg::BMI, cpu_isa_pkg::BVS, cpu_isa_pkg::BCS, cpu_isa_pkg::BEQ};
		if (op == 8'h80)
			return cpu_isa_pkg::BRA;
		if (branch_op(op))
			return tests[{op[5], op[7:6]}]; // Bit 5 picks the set polarity
		if (op == 8'h68)
			return cpu_isa_pkg::LD;
		if (acc_group(op))
			return acc_ops[op[7:5]];
		if (rmw_op(op))
			return rmw_ops[op[7:5]];
		return cpu_isa_pkg::PASS;
	endfunction

	function automatic logic [2:0] exec_sel(input logic [7:0] op);
		if (branch_op(op))
			return cpu_isa_pkg::F;
		if ((op == 8'h48) || acc_group(op))
			return cpu_isa_pkg::A;
		return cpu_isa_pkg::M;
	endfunction

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("mismatch %s: got %02h expected %02h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic check_outputs();
		logic [1:0] sp;
		logic [2:0] wsel;
		logic [3:0] asel;
		logic [2:0] osel;
		logic [5:0] aop;
		logic wr;
		sp = (m_state inside {PUSH, JSR0, JSR1}) ? cu_ctrl_pkg::DEC :
			((m_state == PULL) ? cu_ctrl_pkg::INC : cu_ctrl_pkg::HOLD);
		wr = m_state inside {ZP_STORE, ZP_WRITE, ABS_STORE, ABS_WRITE, PUSH, JSR0, JSR1};
		case (m_state)
			ZP_WRITE, ABS_WRITE: wsel = cu_ctrl_pkg::RESULT;
			JSR0: wsel = cu_ctrl_pkg::PCH;
			JSR1: wsel = cu_ctrl_pkg::PCL;
			default: wsel = cu_ctrl_pkg::ALU;
		endcase
		case (m_state)
			ZP1, ZP_STORE, ZP_WRITE: asel = cu_ctrl_pkg::ZERO;
			ABS2, ABS_STORE, ABS_WRITE: asel = cu_ctrl_pkg::ABS;
			PUSH, PULL, JSR0, JSR1: asel = cu_ctrl_pkg::STACK;
			default: asel = cu_ctrl_pkg::PC;
		endcase
		case (m_state)
			ZP0, ABS0: osel = cpu_isa_pkg::Z;
			IM0, ZP1, ABS2, ZP_STORE, ABS_STORE, PUSH, BRANCH_CHECK: osel = exec_sel(m_op);
			default: osel = cpu_isa_pkg::M;
		endcase
		case (m_state)
			ZP0, ABS0: aop = cpu_isa_pkg::ADR0;
			ABS1: aop = cpu_isa_pkg::ADR1;
			IM0, ZP1, ABS2, BRANCH_CHECK: aop = exec_op(m_op);
			default: aop = cpu_isa_pkg::PASS;
		endcase
		check_value("instruction_load", instruction_load, m_state == FETCH);
		check_value("increment_pc", increment_pc,
			m_state inside {FETCH, IM0, ZP0, ABS0, ABS1, BRANCH_CHECK});
		check_value("dirl_load", dirl_load, m_state inside {ZP0, ABS0});
		check_value("dirh_load", dirh_load, m_state == ABS1);
		check_value("a_load", a_load, loads_acc(m_op) && (m_state inside {IM0, ZP1, ABS2, PULL}));
		check_value("branch_load", branch_load, m_state == BRANCH_GO);
		check_value("jmp_load", jmp_load, m_state == ABS_JMP);
		check_value("jsr_load", jsr_load, m_state == JSR2);
		check_value("sp_op", sp_op, sp);
		check_value("read_write", read_write, wr ? cu_ctrl_pkg::RW_WRITE : cu_ctrl_pkg::RW_READ);
		check_value("write_select", write_select, wsel);
		check_value("address_select", address_select, asel);
		check_value("alu_select", alu_select, osel);
		check_value("alu_opcode", alu_opcode, aop);
	endtask

	task automatic build_opcode_list();
		for (int aaa = 0; aaa < 8; aaa++) begin
			supported.push_back({3'(aaa), 3'b010, 2'b01}); // Includes STA immediate
			supported.push_back({3'(aaa), 3'b001, 2'b01});
			supported.push_back({3'(aaa), 3'b011, 2'b01});
			if ((aaa != 4) && (aaa != 5)) begin
				supported.push_back({3'(aaa), 3'b001, 2'b10});
				supported.push_back({3'(aaa), 3'b011, 2'b10});
			end
			supported.push_back({3'(aaa), 5'b10000}); // Conditional branches
		end
		supported.push_back(8'h80);
		supported.push_back(8'h48);
		supported.push_back(8'h68);
		supported.push_back(8'h4C);
		supported.push_back(8'h20);
	endtask

	function automatic logic [7:0] draw_opcode();
		int r;
		r = $urandom_range(99);
		if (r < 80)
			return supported[$urandom_range(supported.size() - 1)];
		return 8'($urandom_range(255));
	endfunction

	// Per falling edge check, drive new inputs and advance the model
	task automatic step_cycle();
		logic [7:0] next_op;
		logic bv;
		check_outputs();
		next_op = opcode;
		if (instruction_load) begin
			if (started) begin
				check_value("instr_cycles", 8'(len_count), 8'(exp_len));
				instr_done++;
			end
			started = 1'b1;
			len_count = 0;
			next_op = draw_opcode();
			exp_len = cycles_for(next_op);
		end
		len_count++;
		bv = 1'($urandom_range(1));
		if ((m_state == BRANCH_CHECK) && bv)
			exp_len++;
		opcode = next_op;
		branch_valid = bv;
		if (m_state == FETCH) begin
			m_op = next_op;
			m_state = first_state(next_op);
		end else begin
			m_state = advance(m_state, m_op, bv);
		end
	endtask

	initial begin
		rst = 1'b0;
		opcode = 8'h00;
		branch_valid = 1'b0;
		m_state = FETCH;
		m_op = 8'h00;
		started = 1'b0;
		void'($urandom(63));
		build_opcode_list();

		repeat (2) @(negedge clk);
		check_outputs();
		@(negedge clk);
		check_outputs();
		rst = 1'b1; // Three rising edges in reset
		$display("test 1 reset_outputs: %0d errors", errors);

		test_errors = errors;
		while (instr_done < NUM_INSTR) begin
			@(negedge clk);
			step_cycle();
		end
		$display("test 2 random_instructions: %0d instructions, %0d errors",
			instr_done, errors - test_errors);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/cpu_isa_pkg.sv
rtl/cu_ctrl_pkg.sv
rtl/decode_if.sv
rtl/instruction_decoder.sv
rtl/state_sequencer.sv
rtl/micro_op_decoder.sv
rtl/control_unit.sv
verification/tb_control_unit.sv
